// ==== all.f ====
+incdir+src
src/axiPkg.sv
src/ahbPkg.sv
src/axiMstIf.sv
src/regSlice.sv
src/ahbToAxiFsm.sv
src/ahbMasterBridge.sv
verif/axiSlaveModel.sv
verif/tb_ahbMasterBridge.sv

// ==== Makefile ====
# Verilator build and run of the AHB master bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_ahbMasterBridge
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TEST FAIL

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS FAIL_MSG"

# A simulator that stops early also counts as a failure
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_ahbMasterBridge.sv ====
`timescale 1ns/1ps
`include "bridge_defs.svh"

module tb_ahbMasterBridge;

	// 60 AHB transfers in the sequence below
	localparam int numTransfers = 60;
	localparam int cycleLimit   = numTransfers * 12 + 200;

	logic                          aclk;
	logic                          rst;
	logic                          hSel;
	logic [`BRIDGE_ADDR_WIDTH-1:0] hAddr;
	ahbPkg::htransE                hTrans;
	logic                          hWrite;
	ahbPkg::hsizeE                 hSize;
	logic [3:0]                    hProt;
	logic [`BRIDGE_DATA_WIDTH-1:0] hWdata;
	logic [`BRIDGE_DATA_WIDTH-1:0] hRdata;
	logic                          hReady;
	logic                          hResp;

	logic [`BRIDGE_ID_WIDTH-1:0]   awId, bId, arId, rId;
	logic [`BRIDGE_ADDR_WIDTH-1:0] awAddr, arAddr;
	logic [7:0]                    awLen, arLen;
	logic [2:0]                    awSize, awProt, arSize, arProt;
	logic [1:0]                    awBurst, arBurst, bResp, rResp;
	logic [`BRIDGE_DATA_WIDTH-1:0] wData, rData;
	logic [`BRIDGE_STRB_WIDTH-1:0] wStrb;
	logic                          wLast, rLast;
	logic                          awValid, awReady, wValid, wReady, bValid, bReady;
	logic                          arValid, arReady, rValid, rReady;

	// Expected values for the transfer in flight
	string                         testName;
	logic                          started;
	logic                          dataPhase;
	logic                          idleWindow;
	logic                          errExpected;
	logic                          readCheck;
	logic [`BRIDGE_ADDR_WIDTH-1:0] expAddr;
	logic [`BRIDGE_DATA_WIDTH-1:0] expRdata;
	logic [`BRIDGE_DATA_WIDTH-1:0] expWdata;
	logic [2:0]                    expSize;
	logic [2:0]                    expProt;
	logic [`BRIDGE_STRB_WIDTH-1:0] expStrb;
	logic [`BRIDGE_DATA_WIDTH-1:0] refMem [logic [29:0]];
	int                            errorCount;
	int                            transferCount;
	int                            cycleCount = 0;

	logic [49:0]                   awBeat, arBeat, expBeat;
	logic [36:0]                   wBeat, expWBeat;

	assign awBeat   = {awId, awAddr, awLen, awSize, awBurst, awProt};
	assign arBeat   = {arId, arAddr, arLen, arSize, arBurst, arProt};
	assign expBeat  = {2'(`BRIDGE_AXI_ID), expAddr, 8'd0, expSize, 2'(axiPkg::INCR), expProt};
	assign wBeat    = {wData, wStrb, wLast};
	assign expWBeat = {expWdata, expStrb, 1'b1};

	ahbMasterBridge DUT (.*);

	axiSlaveModel slave (.*);

	initial begin
		aclk = 1'b0;
		forever #10 aclk = ~aclk;
	end

	always @(posedge aclk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout, the run did not finish within %0d cycles", cycleLimit);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic reportMismatch(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		errorCount++;
		$display("error %s %s: expected %h actual %h", testName, what, expected, actual);
	endtask

	task automatic reportProblem(input string what);
		errorCount++;
		$display("%s: %s", testName, what);
	endtask

	// Byte lanes covered by a transfer of this size at this offset
	function automatic logic [3:0] laneMask(input ahbPkg::hsizeE size, input logic [1:0] low);
		int         bytes;
		int         first;
		logic [3:0] mask;
		bytes = 1 << int'(size);
		first = int'(low) & ~(bytes - 1);
		for (int i = 0; i < 4; i++) begin
			mask[i] = (i >= first) && (i < first + bytes);
		end
		return mask;
	endfunction

	// AxPROT bit 0 privileged, bit 1 nonsecure, bit 2 instruction
	function automatic logic [2:0] protMap(input logic [3:0] prot);
		logic [2:0] axProt;
		// HPROT[1] marks a privileged access
		axProt[0] = prot[1];
		// Every access from this master is secure
		axProt[1] = 1'b0;
		// HPROT[0] low marks an opcode fetch
		axProt[2] = (prot[0] == 1'b0);
		return axProt;
	endfunction

	function automatic logic [31:0] randomAddr();
		return {16'h0, 14'($urandom_range(63)), 2'b00};
	endfunction

	//////////////////////////////
	// Checks
	//////////////////////////////

	aResetQuiet: assert property (@(posedge aclk) disable iff (rst)
		!started |-> hReady && !hResp && !awValid && !wValid && !arValid)
		else reportProblem("bus left its idle state before the first transfer");

	aReadData: assert property (@(posedge aclk) disable iff (rst)
		dataPhase && readCheck && hReady && !hResp |-> hRdata == expRdata)
		else reportMismatch("hRdata", 64'(expRdata), 64'($sampled(hRdata)));

	aRespEnd: assert property (@(posedge aclk) disable iff (rst)
		dataPhase && hReady |-> hResp == errExpected)
		else reportMismatch("hResp", 64'(errExpected), 64'($sampled(hResp)));

	aErrTwoCycle: assert property (@(posedge aclk) disable iff (rst)
		dataPhase && hResp && !hReady |=> hResp && hReady)
		else reportProblem("error response did not end with hResp and hReady both high");

	aAwBeat: assert property (@(posedge aclk) disable iff (rst)
		awValid |-> awBeat == expBeat)
		else reportMismatch("AW beat", 64'(expBeat), 64'($sampled(awBeat)));

	aArBeat: assert property (@(posedge aclk) disable iff (rst)
		arValid |-> arBeat == expBeat)
		else reportMismatch("AR beat", 64'(expBeat), 64'($sampled(arBeat)));

	aWBeat: assert property (@(posedge aclk) disable iff (rst)
		wValid |-> wBeat == expWBeat)
		else reportMismatch("W beat", 64'(expWBeat), 64'($sampled(wBeat)));

	aAwHold: assert property (@(posedge aclk) disable iff (rst)
		awValid && !awReady |=> awValid && $stable(awBeat))
		else reportProblem("AW valid or payload changed before awReady");

	aArHold: assert property (@(posedge aclk) disable iff (rst)
		arValid && !arReady |=> arValid && $stable(arBeat))
		else reportProblem("AR valid or payload changed before arReady");

	aWHold: assert property (@(posedge aclk) disable iff (rst)
		wValid && !wReady |=> wValid && $stable(wBeat))
		else reportProblem("W valid or payload changed before wReady");

	// One response in flight leaves the slice room to take it at once
	aBReady: assert property (@(posedge aclk) disable iff (rst)
		bValid |-> bReady)
		else reportProblem("bReady was low while a write response was offered");

	aRReady: assert property (@(posedge aclk) disable iff (rst)
		rValid |-> rReady)
		else reportProblem("rReady was low while read data was offered");

	aIdleQuiet: assert property (@(posedge aclk) disable iff (rst)
		idleWindow |-> hReady && !awValid && !wValid && !arValid)
		else reportProblem("AXI traffic or a wait state during IDLE, BUSY or hSel low");

	//////////////////////////////
	// AHB stimulus
	//////////////////////////////

	task automatic transfer(input logic write, input logic [31:0] addr,
		input ahbPkg::hsizeE size, input logic [31:0] data,
		input ahbPkg::htransE trans, input logic inBurst);
		logic [3:0]  prot;
		logic [31:0] word;
		prot        = 4'($urandom_range(15));
		expAddr     = addr;
		expSize     = 3'(size);
		expProt     = protMap(prot);
		expStrb     = laneMask(size, addr[1:0]);
		expWdata    = data;
		errExpected = addr[31];
		readCheck   = !write && !addr[31] && refMem.exists(addr[31:2]);
		if (readCheck) begin
			expRdata  = refMem[addr[31:2]];
			readCheck = !$isunknown(expRdata);
		end
		hSel    = 1'b1;
		hTrans  = trans;
		hAddr   = addr;
		hWrite  = write;
		hSize   = size;
		hProt   = prot;
		started = 1'b1;
		@(negedge aclk);
		// Bursts keep the slave selected with BUSY in the data phase
		hSel      = inBurst;
		hTrans    = inBurst ? ahbPkg::BUSY : ahbPkg::IDLE;
		hWdata    = data;
		dataPhase = 1'b1;
		while (!hReady) begin
			@(negedge aclk);
		end
		@(negedge aclk);
		dataPhase = 1'b0;
		if (write && !addr[31]) begin
			word = refMem.exists(addr[31:2]) ? refMem[addr[31:2]] : 'x;
			for (int i = 0; i < 4; i++) begin
				if (expStrb[i]) begin
					word[8*i +: 8] = data[8*i +: 8];
				end
			end
			refMem[addr[31:2]] = word;
		end
		transferCount++;
	endtask

	task automatic quietCycles(input int n);
		idleWindow = 1'b1;
		repeat (n) begin
			hSel   = 1'($urandom_range(1));
			hAddr  = $urandom;
			hWrite = 1'($urandom_range(1));
			hTrans = hSel ? ahbPkg::htransE'($urandom_range(1)) : ahbPkg::NONSEQ;
			@(negedge aclk);
		end
		hSel   = 1'b0;
		hTrans = ahbPkg::IDLE;
		@(negedge aclk);
		idleWindow = 1'b0;
	endtask

	initial begin : stimulus
		logic [31:0]   addr;
		logic [1:0]    lane;
		ahbPkg::hsizeE size;
		void'($urandom(55));
		rst           = 1'b1;
		hSel          = 1'b0;
		hAddr         = '0;
		hTrans        = ahbPkg::IDLE;
		hWrite        = 1'b0;
		hSize         = ahbPkg::SIZE_WORD;
		hProt         = 4'b0011;
		hWdata        = '0;
		started       = 1'b0;
		dataPhase     = 1'b0;
		idleWindow    = 1'b0;
		errExpected   = 1'b0;
		readCheck     = 1'b0;
		expAddr       = '0;
		expRdata      = '0;
		expWdata      = '0;
		expSize       = '0;
		expProt       = '0;
		expStrb       = '0;
		errorCount    = 0;
		transferCount = 0;
		testName      = "reset";
		repeat (5) @(negedge aclk);
		rst = 1'b0;
		quietCycles(4);

		testName = "wordRw";
		repeat (8) begin
			addr = randomAddr();
			transfer(1'b1, addr, ahbPkg::SIZE_WORD, $urandom, ahbPkg::NONSEQ, 1'b0);
			transfer(1'b0, addr, ahbPkg::SIZE_WORD, '0, ahbPkg::NONSEQ, 1'b0);
		end

		testName = "subword";
		repeat (8) begin
			addr = randomAddr();
			transfer(1'b1, addr, ahbPkg::SIZE_WORD, $urandom, ahbPkg::NONSEQ, 1'b0);
			size = ahbPkg::hsizeE'($urandom_range(1));
			lane = 2'($urandom_range(3));
			if (size == ahbPkg::SIZE_HALF) begin
				lane[0] = 1'b0;
			end
			transfer(1'b1, {addr[31:2], lane}, size, $urandom, ahbPkg::NONSEQ, 1'b0);
			transfer(1'b0, addr, ahbPkg::SIZE_WORD, '0, ahbPkg::NONSEQ, 1'b0);
		end

		// INCR4 write burst and a read back of the same four words
		testName = "burst";
		repeat (2) begin
			addr = randomAddr();
			for (int i = 0; i < 4; i++) begin
				transfer(1'b1, addr + 32'(4 * i), ahbPkg::SIZE_WORD, $urandom,
					(i == 0) ? ahbPkg::NONSEQ : ahbPkg::SEQ, 1'b1);
			end
			for (int i = 0; i < 4; i++) begin
				transfer(1'b0, addr + 32'(4 * i), ahbPkg::SIZE_WORD, '0,
					(i == 0) ? ahbPkg::NONSEQ : ahbPkg::SEQ, 1'b1);
			end
		end

		testName = "error";
		repeat (2) begin
			addr = randomAddr() | 32'h8000_0000;
			transfer(1'b1, addr, ahbPkg::SIZE_WORD, $urandom, ahbPkg::NONSEQ, 1'b0);
			transfer(1'b0, addr, ahbPkg::SIZE_WORD, '0, ahbPkg::NONSEQ, 1'b0);
		end

		testName = "idle";
		quietCycles(12);

		$display("Run complete: %0d transfers, %0d errors, %0d cycles",
			transferCount, errorCount, cycleCount);
		if (errorCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== verif/axiSlaveModel.sv ====
`timescale 1ns/1ps
`include "bridge_defs.svh"

module axiSlaveModel (
	input  logic                          aclk,
	input  logic                          rst,

	input  logic [`BRIDGE_ID_WIDTH-1:0]   awId,
	input  logic [`BRIDGE_ADDR_WIDTH-1:0] awAddr,
	input  logic                          awValid,
	output logic                          awReady,

	input  logic [`BRIDGE_DATA_WIDTH-1:0] wData,
	input  logic [`BRIDGE_STRB_WIDTH-1:0] wStrb,
	input  logic                          wValid,
	output logic                          wReady,

	output logic [`BRIDGE_ID_WIDTH-1:0]   bId,
	output logic [1:0]                    bResp,
	output logic                          bValid,
	input  logic                          bReady,

	input  logic [`BRIDGE_ID_WIDTH-1:0]   arId,
	input  logic [`BRIDGE_ADDR_WIDTH-1:0] arAddr,
	input  logic                          arValid,
	output logic                          arReady,

	output logic [`BRIDGE_ID_WIDTH-1:0]   rId,
	output logic [`BRIDGE_DATA_WIDTH-1:0] rData,
	output logic [1:0]                    rResp,
	output logic                          rLast,
	output logic                          rValid,
	input  logic                          rReady
);

	logic [`BRIDGE_DATA_WIDTH-1:0] mem [logic [29:0]];

	// Unwritten words return a pattern made from their own address
	function automatic logic [`BRIDGE_DATA_WIDTH-1:0] readWord(input logic [29:0] idx);
		if (mem.exists(idx)) begin
			return mem[idx];
		end
		return {idx, 2'b00} ^ 32'h5A5A_A5A5;
	endfunction

	task automatic randomStall();
		repeat ($urandom_range(3)) @(negedge aclk);
	endtask

	//////////////////////////////
	// Write side
	//////////////////////////////

	initial begin : writeSide
		logic [`BRIDGE_ADDR_WIDTH-1:0] addr;
		logic [`BRIDGE_ID_WIDTH-1:0]   id;
		logic [`BRIDGE_DATA_WIDTH-1:0] word;
		awReady = 1'b0;
		wReady  = 1'b0;
		bValid  = 1'b0;
		bId     = '0;
		bResp   = 2'b00;
		forever begin
			@(negedge aclk);
			while (rst || awValid !== 1'b1) begin
				@(negedge aclk);
			end
			randomStall();
			awReady = 1'b1;
			addr    = awAddr;
			id      = awId;
			@(negedge aclk);
			awReady = 1'b0;
			while (wValid !== 1'b1) begin
				@(negedge aclk);
			end
			randomStall();
			wReady = 1'b1;
			word   = readWord(addr[31:2]);
			for (int i = 0; i < `BRIDGE_STRB_WIDTH; i++) begin
				if (wStrb[i]) begin
					word[8*i +: 8] = wData[8*i +: 8];
				end
			end
			@(negedge aclk);
			wReady = 1'b0;
			// Upper half of the map is unmapped
			if (!addr[31]) begin
				mem[addr[31:2]] = word;
			end
			randomStall();
			bId    = id;
			bResp  = addr[31] ? 2'b10 : 2'b00;
			bValid = 1'b1;
			while (bReady !== 1'b1) begin
				@(negedge aclk);
			end
			@(negedge aclk);
			bValid = 1'b0;
		end
	end

	//////////////////////////////
	// Read side
	//////////////////////////////

	initial begin : readSide
		logic [`BRIDGE_ADDR_WIDTH-1:0] addr;
		logic [`BRIDGE_ID_WIDTH-1:0]   id;
		arReady = 1'b0;
		rValid  = 1'b0;
		rId     = '0;
		rData   = '0;
		rResp   = 2'b00;
		rLast   = 1'b0;
		forever begin
			@(negedge aclk);
			while (rst || arValid !== 1'b1) begin
				@(negedge aclk);
			end
			randomStall();
			arReady = 1'b1;
			addr    = arAddr;
			id      = arId;
			@(negedge aclk);
			arReady = 1'b0;
			randomStall();
			rId    = id;
			rData  = addr[31] ? '0 : readWord(addr[31:2]);
			rResp  = addr[31] ? 2'b10 : 2'b00;
			rLast  = 1'b1;
			rValid = 1'b1;
			while (rReady !== 1'b1) begin
				@(negedge aclk);
			end
			@(negedge aclk);
			rValid = 1'b0;
		end
	end

endmodule

// ==== src/ahbMasterBridge.sv ====
`timescale 1ns/1ps
`include "bridge_defs.svh"

module ahbMasterBridge (
	input  logic                          aclk,
	input  logic                          rst,

	// AHB-Lite
	input  logic                          hSel,
	input  logic [`BRIDGE_ADDR_WIDTH-1:0] hAddr,
	input  ahbPkg::htransE                hTrans,
	input  logic                          hWrite,
	input  ahbPkg::hsizeE                 hSize,
	input  logic [3:0]                    hProt,
	input  logic [`BRIDGE_DATA_WIDTH-1:0] hWdata,
	output logic [`BRIDGE_DATA_WIDTH-1:0] hRdata,
	output logic                          hReady,
	output logic                          hResp,

	// AXI write address
	output logic [`BRIDGE_ID_WIDTH-1:0]   awId,
	output logic [`BRIDGE_ADDR_WIDTH-1:0] awAddr,
	output logic [7:0]                    awLen,
	output logic [2:0]                    awSize,
	output logic [1:0]                    awBurst,
	output logic [2:0]                    awProt,
	output logic                          awValid,
	input  logic                          awReady,

	// AXI write data
	output logic [`BRIDGE_DATA_WIDTH-1:0] wData,
	output logic [`BRIDGE_STRB_WIDTH-1:0] wStrb,
	output logic                          wLast,
	output logic                          wValid,
	input  logic                          wReady,

	// AXI write response
	input  logic [`BRIDGE_ID_WIDTH-1:0]   bId,
	input  logic [1:0]                    bResp,
	input  logic                          bValid,
	output logic                          bReady,

	// AXI read address
	output logic [`BRIDGE_ID_WIDTH-1:0]   arId,
	output logic [`BRIDGE_ADDR_WIDTH-1:0] arAddr,
	output logic [7:0]                    arLen,
	output logic [2:0]                    arSize,
	output logic [1:0]                    arBurst,
	output logic [2:0]                    arProt,
	output logic                          arValid,
	input  logic                          arReady,

	// AXI read data
	input  logic [`BRIDGE_ID_WIDTH-1:0]   rId,
	input  logic [`BRIDGE_DATA_WIDTH-1:0] rData,
	input  logic [1:0]                    rResp,
	input  logic                          rLast,
	input  logic                          rValid,
	output logic                          rReady
);

	axiMstIf fsmBus();
	axiMstIf xbarBus();

	ahbToAxiFsm fsm (
		.aclk(aclk),
		.rst(rst),
		.hSel(hSel),
		.hAddr(hAddr),
		.hTrans(hTrans),
		.hWrite(hWrite),
		.hSize(hSize),
		.hProt(hProt),
		.hWdata(hWdata),
		.hRdata(hRdata),
		.hReady(hReady),
		.hResp(hResp),
		.bus(fsmBus.master)
	);

	//////////////////////////////
	// Channel slices
	//////////////////////////////

	regSlice #(.payloadT(axiPkg::axiAddrT)) awSlice (
		.aclk(aclk), .rst(rst),
		.srcValid(fsmBus.awValid), .srcReady(fsmBus.awReady), .srcData(fsmBus.awPayload),
		.dstValid(xbarBus.awValid), .dstReady(xbarBus.awReady), .dstData(xbarBus.awPayload)
	);

	regSlice #(.payloadT(axiPkg::axiWdataT)) wSlice (
		.aclk(aclk), .rst(rst),
		.srcValid(fsmBus.wValid), .srcReady(fsmBus.wReady), .srcData(fsmBus.wPayload),
		.dstValid(xbarBus.wValid), .dstReady(xbarBus.wReady), .dstData(xbarBus.wPayload)
	);

	regSlice #(.payloadT(axiPkg::axiAddrT)) arSlice (
		.aclk(aclk), .rst(rst),
		.srcValid(fsmBus.arValid), .srcReady(fsmBus.arReady), .srcData(fsmBus.arPayload),
		.dstValid(xbarBus.arValid), .dstReady(xbarBus.arReady), .dstData(xbarBus.arPayload)
	);

	// Responses run from the crossbar back toward the FSM
	regSlice #(.payloadT(axiPkg::axiBrespT)) bSlice (
		.aclk(aclk), .rst(rst),
		.srcValid(xbarBus.bValid), .srcReady(xbarBus.bReady), .srcData(xbarBus.bPayload),
		.dstValid(fsmBus.bValid), .dstReady(fsmBus.bReady), .dstData(fsmBus.bPayload)
	);

	regSlice #(.payloadT(axiPkg::axiRdataT)) rSlice (
		.aclk(aclk), .rst(rst),
		.srcValid(xbarBus.rValid), .srcReady(xbarBus.rReady), .srcData(xbarBus.rPayload),
		.dstValid(fsmBus.rValid), .dstReady(fsmBus.rReady), .dstData(fsmBus.rPayload)
	);

	//////////////////////////////
	// Crossbar-side port mapping
	//////////////////////////////

	assign awId    = xbarBus.awPayload.id;
	assign awAddr  = xbarBus.awPayload.addr;
	assign awLen   = xbarBus.awPayload.len;
	assign awSize  = xbarBus.awPayload.size;
	assign awBurst = xbarBus.awPayload.burst;
	assign awProt  = xbarBus.awPayload.prot;
	assign awValid = xbarBus.awValid;
	assign xbarBus.awReady = awReady;

	assign wData  = xbarBus.wPayload.data;
	assign wStrb  = xbarBus.wPayload.strb;
	assign wLast  = xbarBus.wPayload.last;
	assign wValid = xbarBus.wValid;
	assign xbarBus.wReady = wReady;

	assign xbarBus.bPayload = '{id: bId, resp: axiPkg::axiRespE'(bResp)};
	assign xbarBus.bValid   = bValid;
	assign bReady = xbarBus.bReady;

	assign arId    = xbarBus.arPayload.id;
	assign arAddr  = xbarBus.arPayload.addr;
	assign arLen   = xbarBus.arPayload.len;
	assign arSize  = xbarBus.arPayload.size;
	assign arBurst = xbarBus.arPayload.burst;
	assign arProt  = xbarBus.arPayload.prot;
	assign arValid = xbarBus.arValid;
	assign xbarBus.arReady = arReady;

	assign xbarBus.rPayload = '{
		id:   rId,
		data: rData,
		resp: axiPkg::axiRespE'(rResp),
		last: rLast
	};
	assign xbarBus.rValid = rValid;
	assign rReady = xbarBus.rReady;

endmodule

// ==== src/ahbToAxiFsm.sv ====
`timescale 1ns/1ps
`include "bridge_defs.svh"

module ahbToAxiFsm (
	input  logic                          aclk,
	input  logic                          rst,

	input  logic                          hSel,
	input  logic [`BRIDGE_ADDR_WIDTH-1:0] hAddr,
	input  ahbPkg::htransE                hTrans,
	input  logic                          hWrite,
	input  ahbPkg::hsizeE                 hSize,
	input  logic [3:0]                    hProt,
	input  logic [`BRIDGE_DATA_WIDTH-1:0] hWdata,
	output logic [`BRIDGE_DATA_WIDTH-1:0] hRdata,
	output logic                          hReady,
	output logic                          hResp,

	axiMstIf.master                       bus
);

	localparam logic [`BRIDGE_ID_WIDTH-1:0] masterId = `BRIDGE_AXI_ID;

	typedef enum logic [2:0] {
		S_IDLE,
		S_WR_ISSUE,
		S_WR_RESP,
		S_RD_ISSUE,
		S_RD_DATA,
		S_ERR1,
		S_ERR2
	} stateE;

	stateE                         state;
	logic [`BRIDGE_ADDR_WIDTH-1:0] capAddr;
	ahbPkg::hsizeE                 capSize;
	logic [2:0]                    capProt;
	logic [`BRIDGE_DATA_WIDTH-1:0] capWdata;
	axiPkg::axiAddrT               addrBeat;
	logic                          addrAccept;
	logic                          awDone;
	logic                          wDone;
	logic                          bFire;
	logic                          rFire;

	// Byte lanes of a transfer on the 32-bit bus
	function automatic logic [`BRIDGE_STRB_WIDTH-1:0] strbFor(
		input ahbPkg::hsizeE size,
		input logic [1:0]    lowAddr
	);
		logic [`BRIDGE_STRB_WIDTH-1:0] strb;
		case (size)
			ahbPkg::SIZE_BYTE: strb = 4'b0001 << lowAddr;
			ahbPkg::SIZE_HALF: strb = 4'b0011 << {lowAddr[1], 1'b0};
			default:           strb = {`BRIDGE_STRB_WIDTH{1'b1}};
		endcase
		return strb;
	endfunction

	function automatic logic respIsErr(input axiPkg::axiRespE resp);
		return (resp == axiPkg::SLVERR) || (resp == axiPkg::DECERR);
	endfunction

	//////////////////////////////
	// AHB address phase
	//////////////////////////////

	// IDLE and BUSY fall through with OKAY
	assign addrAccept = hSel && hReady
		&& (hTrans == ahbPkg::NONSEQ || hTrans == ahbPkg::SEQ);

	assign awDone = !bus.awValid || bus.awReady;
	assign wDone  = !bus.wValid || bus.wReady;
	assign bFire  = bus.bValid && bus.bReady;
	assign rFire  = bus.rValid && bus.rReady;

	// One beat, incrementing, fixed ID
	assign addrBeat = '{
		id:    masterId,
		addr:  capAddr,
		len:   8'd0,
		size:  3'(capSize),
		burst: axiPkg::INCR,
		prot:  capProt
	};

	assign bus.awPayload = addrBeat;
	assign bus.arPayload = addrBeat;
	assign bus.wPayload  = '{
		data: capWdata,
		strb: strbFor(capSize, capAddr[1:0]),
		last: 1'b1
	};

	always_ff @(posedge aclk) begin
		if (addrAccept) begin
			capAddr <= hAddr;
			capSize <= hSize;
			// Instruction, secure, privileged
			capProt <= {~hProt[0], 1'b0, hProt[1]};
		end
		if (state == S_WR_ISSUE) begin
			capWdata <= hWdata;
		end
		if (rFire) begin
			hRdata <= bus.rPayload.data;
		end
	end

	//////////////////////////////
	// Transaction FSM
	//////////////////////////////

	always_ff @(posedge aclk) begin
		if (rst) begin
			state       <= S_IDLE;
			hReady      <= 1'b1;
			hResp       <= 1'b0;
			bus.awValid <= 1'b0;
			bus.wValid  <= 1'b0;
			bus.bReady  <= 1'b0;
			bus.arValid <= 1'b0;
			bus.rReady  <= 1'b0;
		end else begin
			case (state)
				S_IDLE, S_ERR2: begin
					hResp <= 1'b0;
					state <= S_IDLE;
					if (addrAccept) begin
						hReady <= 1'b0;
						if (hWrite) begin
							state <= S_WR_ISSUE;
						end else begin
							state       <= S_RD_ISSUE;
							bus.arValid <= 1'b1;
						end
					end
				end
				// hWdata is on the bus this cycle
				S_WR_ISSUE: begin
					bus.awValid <= 1'b1;
					bus.wValid  <= 1'b1;
					state       <= S_WR_RESP;
				end
				S_WR_RESP: begin
					if (bus.awReady) begin
						bus.awValid <= 1'b0;
					end
					if (bus.wReady) begin
						bus.wValid <= 1'b0;
					end
					// AW and W may finish in either order
					if (awDone && wDone && !bus.bReady) begin
						bus.bReady <= 1'b1;
					end
					if (bFire) begin
						bus.bReady <= 1'b0;
						if (respIsErr(bus.bPayload.resp)) begin
							hResp <= 1'b1;
							state <= S_ERR1;
						end else begin
							hReady <= 1'b1;
							state  <= S_IDLE;
						end
					end
				end
				S_RD_ISSUE: begin
					if (bus.arReady) begin
						bus.arValid <= 1'b0;
						bus.rReady  <= 1'b1;
						state       <= S_RD_DATA;
					end
				end
				S_RD_DATA: begin
					if (rFire) begin
						bus.rReady <= 1'b0;
						if (respIsErr(bus.rPayload.resp)) begin
							hResp <= 1'b1;
							state <= S_ERR1;
						end else begin
							hReady <= 1'b1;
							state  <= S_IDLE;
						end
					end
				end
				// Second half of the two-cycle error
				S_ERR1: begin
					hReady <= 1'b1;
					state  <= S_ERR2;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// One transaction open, so never both address channels at once
	aOneAddr: assert property (@(posedge aclk) disable iff (rst)
		!(bus.awValid && bus.arValid));

	aIdleReady: assert property (@(posedge aclk) disable iff (rst)
		state == S_IDLE |-> hReady && !hResp);

endmodule

// ==== src/regSlice.sv ====
`timescale 1ns/1ps

module regSlice #(
	parameter type payloadT = logic
) (
	input  logic    aclk,
	input  logic    rst,

	input  logic    srcValid,
	output logic    srcReady,
	input  payloadT srcData,

	output logic    dstValid,
	input  logic    dstReady,
	output payloadT dstData
);

	logic    mainValid;
	logic    skidValid;
	payloadT mainData;
	payloadT skidData;
	logic    srcFire;
	logic    mainFree;

	assign srcFire  = srcValid && srcReady;
	// Main entry empties or moves on this cycle
	assign mainFree = !mainValid || dstReady;

	// Ready comes straight from a flop
	assign srcReady = !skidValid;
	assign dstValid = mainValid;
	assign dstData  = mainData;

	always_ff @(posedge aclk) begin
		if (rst) begin
			mainValid <= 1'b0;
			skidValid <= 1'b0;
		end else if (mainFree) begin
			// Skid drains first, else take the new beat
			mainValid <= skidValid || srcFire;
			skidValid <= 1'b0;
		end else if (srcFire) begin
			skidValid <= 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (mainFree) begin
			mainData <= skidValid ? skidData : srcData;
		end
		if (srcFire && !mainFree) begin
			skidData <= srcData;
		end
	end

	// Stalled output beat must not change
	aDstHold: assert property (@(posedge aclk) disable iff (rst)
		dstValid && !dstReady |=> dstValid && $stable(dstData));

	// Filling the skid entry closes the source side
	aNoOverrun: assert property (@(posedge aclk) disable iff (rst)
		srcFire && mainValid && !dstReady |=> !srcReady);

endmodule

// ==== src/axiMstIf.sv ====
`timescale 1ns/1ps

interface axiMstIf;

	// Write address
	logic awValid;
	logic awReady;
	axiPkg::axiAddrT awPayload;

	// Write data
	logic wValid;
	logic wReady;
	axiPkg::axiWdataT wPayload;

	// Write response
	logic bValid;
	logic bReady;
	axiPkg::axiBrespT bPayload;

	// Read address
	logic arValid;
	logic arReady;
	axiPkg::axiAddrT arPayload;

	// Read data
	logic rValid;
	logic rReady;
	axiPkg::axiRdataT rPayload;

	modport master (
		output awValid, awPayload, input awReady,
		output wValid, wPayload, input wReady,
		input bValid, bPayload, output bReady,
		output arValid, arPayload, input arReady,
		input rValid, rPayload, output rReady
	);

	modport slave (
		input awValid, awPayload, output awReady,
		input wValid, wPayload, output wReady,
		output bValid, bPayload, input bReady,
		input arValid, arPayload, output arReady,
		output rValid, rPayload, input rReady
	);

endinterface

// ==== src/ahbPkg.sv ====
package ahbPkg;

	// hTrans encoding
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htransE;

	// Only the sizes that fit a 32-bit data bus
	typedef enum logic [2:0] {
		SIZE_BYTE = 3'b000,
		SIZE_HALF = 3'b001,
		SIZE_WORD = 3'b010
	} hsizeE;

	// Burst hints, accepted and then treated as single transfers
	typedef enum logic [2:0] {
		SINGLE = 3'b000,
		INCR   = 3'b001,
		WRAP4  = 3'b010,
		INCR4  = 3'b011,
		WRAP8  = 3'b100,
		INCR8  = 3'b101,
		WRAP16 = 3'b110,
		INCR16 = 3'b111
	} hburstE;

endpackage

// ==== src/axiPkg.sv ====
`include "bridge_defs.svh"

package axiPkg;

	// BRESP / RRESP encoding
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axiRespE;

	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} axiBurstE;

	// Shared by AW and AR
	typedef struct packed {
		logic [`BRIDGE_ID_WIDTH-1:0]   id;
		logic [`BRIDGE_ADDR_WIDTH-1:0] addr;
		logic [7:0]                    len;
		logic [2:0]                    size;
		axiBurstE                      burst;
		logic [2:0]                    prot;
	} axiAddrT;

	typedef struct packed {
		logic [`BRIDGE_DATA_WIDTH-1:0] data;
		logic [`BRIDGE_STRB_WIDTH-1:0] strb;
		logic                          last;
	} axiWdataT;

	typedef struct packed {
		logic [`BRIDGE_ID_WIDTH-1:0] id;
		axiRespE                     resp;
	} axiBrespT;

	typedef struct packed {
		logic [`BRIDGE_ID_WIDTH-1:0]   id;
		logic [`BRIDGE_DATA_WIDTH-1:0] data;
		axiRespE                       resp;
		logic                          last;
	} axiRdataT;

endpackage

// ==== src/bridge_defs.svh ====
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// AHB and AXI address width
`define BRIDGE_ADDR_WIDTH 32

// Data path, equal on both sides of the bridge
`define BRIDGE_DATA_WIDTH 32
`define BRIDGE_STRB_WIDTH 4

// AXI ID width at the crossbar port
`define BRIDGE_ID_WIDTH 2

// AWID and ARID of every transaction from this master
`define BRIDGE_AXI_ID 1

`endif
